// File: project.f
+incdir+logic
logic/permuterPkg.sv
logic/syncFifo.sv
logic/botPermuter.sv
logic/botPermuterWithFifo.sv
logic/batchBotBuffer.sv
logic/batchDispatcher.sv
logic/botPermuterWithMultiFifo.sv
tb/botPermuterTb.sv

// File: tb/botPermuterTb.sv
`timescale 1ns/100ps

`include "permuter_cfg.svh"

module botPermuterTb;

    import permuterPkg::*;

    localparam int maxRows = 16;

    logic clk;
    logic rst;
    botT bots [`NUM_SOURCES];
    permMaskT validBotsPermutes [`NUM_SOURCES];
    logic [`NUM_SOURCES-1:0] writes;
    logic [`NUM_SOURCES-1:0] batchesDone;
    logic [`NUM_SOURCES-1:0] slowDownInputs;
    botT permutedBot;
    logic permutedBotValid;
    logic batchFinished;
    logic requestSlowDown;

    // Stimulus table, one row per batch
    int rowTest [maxRows];
    int rowSrc [maxRows];
    int rowCount [maxRows];
    logic rowRandMask [maxRows];
    permMaskT rowMask [maxRows];
    // 0 closes in its own cycle, 1 with the last write, 2 holds the batch open first
    int rowClose [maxRows];
    logic rowSlow [maxRows];
    int numRows;

    // Expected outputs in order, bit 128 marks a batchFinished pulse
    logic [128:0] expected [$];
    int checkCount;
    int errorCount;
    int errorsAtStart;
    int watchdogCycles;
    logic randomSlowDown;

    botPermuterWithMultiFifo dut (
        .clk(clk),
        .rst(rst),
        .bots(bots),
        .validBotsPermutes(validBotsPermutes),
        .writes(writes),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input logic [128:0] actual, input logic [128:0] want,
                              input string what);
        checkCount++;
        if (actual !== want) begin
            errorCount++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, want);
        end
    endtask

    // Slot order per mask bit, each 2-bit field names a variable (0 A, 1 B, 2 C)
    function automatic botT permuteModel(input botT src, input int pos);
        logic [5:0] order;
        logic [6:0] jv;
        logic [6:0] k;
        botT res;
        case (pos)
            5: order = {2'd0, 2'd1, 2'd2};
            4: order = {2'd0, 2'd2, 2'd1};
            3: order = {2'd1, 2'd0, 2'd2};
            2: order = {2'd1, 2'd2, 2'd0};
            1: order = {2'd2, 2'd0, 2'd1};
            default: order = {2'd2, 2'd1, 2'd0};
        endcase
        for (int j = 0; j < 128; j++) begin
            jv = 7'(j);
            // Variable v sits at index bit 6 - v
            k[6] = jv[6 - order[5:4]];
            k[5] = jv[6 - order[3:2]];
            k[4] = jv[6 - order[1:0]];
            k[3:0] = jv[3:0];
            res[j] = src[k];
        end
        return res;
    endfunction

    task automatic addRow(input int test, input int src, input int count, input logic randMask,
                          input permMaskT mask, input int closeMode, input logic slow);
        rowTest[numRows] = test;
        rowSrc[numRows] = src;
        rowCount[numRows] = count;
        rowRandMask[numRows] = randMask;
        rowMask[numRows] = mask;
        rowClose[numRows] = closeMode;
        rowSlow[numRows] = slow;
        numRows++;
    endtask

    // Highest mask bit comes out first
    task automatic expectItem(input botT bot, input permMaskT mask);
        for (int p = 5; p >= 0; p--) begin
            if (mask[p]) begin
                expected.push_back({1'b0, permuteModel(bot, p)});
            end
        end
    endtask

    task automatic applyRow(input int r);
        botT bot;
        permMaskT mask;
        int src;
        src = rowSrc[r];
        for (int n = 0; n < rowCount[r]; n++) begin
            @(negedge clk);
            bot = {$urandom, $urandom, $urandom, $urandom};
            mask = rowRandMask[r] ? permMaskT'($urandom) : rowMask[r];
            bots[src] = bot;
            validBotsPermutes[src] = mask;
            writes[src] = 1'b1;
            batchesDone[src] = (n == rowCount[r] - 1) && (rowClose[r] == 1);
            expectItem(bot, mask);
        end
        @(negedge clk);
        writes = '0;
        batchesDone = '0;
        if (rowClose[r] == 2) begin
            repeat (2) @(negedge clk);
            checkValue(129'(slowDownInputs), 129'(1 << src), "slowDownInputs with open batch");
        end
        if (rowClose[r] != 1 || rowCount[r] == 0) begin
            batchesDone[src] = 1'b1;
            @(negedge clk);
            batchesDone = '0;
        end
        expected.push_back({1'b1, 128'b0});
    endtask

    task automatic finishTest(input int test);
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // Idle gap catches stray outputs
        repeat (20) @(negedge clk);
        randomSlowDown = 1'b0;
        $display("Test %0d done, %0d errors", test, errorCount - errorsAtStart);
        errorsAtStart = errorCount;
    endtask

    always @(negedge clk) begin
        if (randomSlowDown) begin
            requestSlowDown <= 1'($urandom);
        end else begin
            requestSlowDown <= 1'b0;
        end
    end

    always @(posedge clk) begin : monitor
        logic [128:0] want;
        if (!rst) begin
            if (permutedBotValid) begin
                if (expected.size() == 0) begin
                    errorCount++;
                    $display("Unexpected permuted bot at %0t ns, model has nothing left", $time);
                end else begin
                    want = expected.pop_front();
                    checkValue({1'b0, permutedBot}, want, "permuted bot");
                end
            end
            if (batchFinished) begin
                if (expected.size() == 0) begin
                    errorCount++;
                    $display("Unexpected batchFinished at %0t ns, model has nothing left", $time);
                end else begin
                    want = expected.pop_front();
                    checkValue({1'b1, 128'b0}, want, "batchFinished");
                end
            end
        end
    end

    initial begin
        wait (watchdogCycles != 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d expected outputs never arrived",
                 watchdogCycles, expected.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        int totalItems;
        void'($urandom(32'h2361));
        rst = 1'b1;
        writes = '0;
        batchesDone = '0;
        requestSlowDown = 1'b0;
        randomSlowDown = 1'b0;
        for (int i = 0; i < `NUM_SOURCES; i++) begin
            bots[i] = '0;
            validBotsPermutes[i] = '0;
        end
        checkCount = 0;
        errorCount = 0;
        errorsAtStart = 0;
        numRows = 0;

        addRow(2, 0, 3, 1'b0, 6'h3F, 1, 1'b0);
        addRow(3, 1, 4, 1'b0, 6'h00, 0, 1'b0);
        addRow(3, 2, 3, 1'b0, 6'b010100, 1, 1'b0);
        addRow(3, 3, 0, 1'b0, 6'h3F, 0, 1'b0);
        addRow(3, 0, 5, 1'b1, 6'h00, 1, 1'b0);
        addRow(4, 2, 5, 1'b1, 6'h00, 1, 1'b0);
        addRow(4, 0, 2, 1'b0, 6'h21, 0, 1'b0);
        addRow(4, 3, 4, 1'b1, 6'h00, 1, 1'b0);
        addRow(4, 1, 3, 1'b1, 6'h00, 0, 1'b0);
        addRow(5, 0, 8, 1'b1, 6'h00, 1, 1'b1);
        addRow(5, 1, 6, 1'b1, 6'h00, 0, 1'b1);
        addRow(5, 2, 6, 1'b0, 6'h3F, 1, 1'b1);
        addRow(6, 3, 48, 1'b0, 6'h01, 2, 1'b0);

        totalItems = 0;
        for (int r = 0; r < numRows; r++) begin
            totalItems += rowCount[r];
        end
        // Up to six emissions per item, plus room for gaps and slow-down
        watchdogCycles = totalItems * 6 + 2000;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        checkValue(129'({permutedBotValid, batchFinished, slowDownInputs}), 129'(0),
                   "outputs after reset");
        $display("Test 1 done, %0d errors", errorCount - errorsAtStart);
        errorsAtStart = errorCount;

        for (int r = 0; r < numRows; r++) begin
            if (rowSlow[r]) begin
                randomSlowDown = 1'b1;
            end
            applyRow(r);
            if (r == numRows - 1 || rowTest[r + 1] != rowTest[r]) begin
                finishTest(rowTest[r]);
            end
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: logic/botPermuterWithMultiFifo.sv
`timescale 1ns/100ps

`include "permuter_cfg.svh"

module botPermuterWithMultiFifo (
    input  logic                     clk,
    input  logic                     rst,
    input  permuterPkg::botT         bots [`NUM_SOURCES],
    input  permuterPkg::permMaskT    validBotsPermutes [`NUM_SOURCES],
    input  logic [`NUM_SOURCES-1:0]  writes,
    input  logic [`NUM_SOURCES-1:0]  batchesDone,
    output logic [`NUM_SOURCES-1:0]  slowDownInputs,
    output permuterPkg::botT         permutedBot,
    output logic                     permutedBotValid,
    output logic                     batchFinished,
    input  logic                     requestSlowDown
);

    import permuterPkg::*;

    botT bufBots [`NUM_SOURCES];
    permMaskT bufMasks [`NUM_SOURCES];
    batchSizeT batchSizes [`NUM_SOURCES];
    logic [`NUM_SOURCES-1:0] bufSlowDown;
    logic [`NUM_SOURCES-1:0] bufReads;
    botT mergedBot;
    permMaskT mergedMask;
    logic batchQueueNearlyFull;
    logic itemWrite;
    logic batchEnd;
    logic stageSlowDown;

    for (genvar i = 0; i < `NUM_SOURCES; i++) begin : sources
        batchBotBuffer sourceBuffer (
            .clk(clk),
            .rst(rst),
            .write(writes[i]),
            .botIn(bots[i]),
            .validBotPermutesIn(validBotsPermutes[i]),
            .endBatch(batchesDone[i]),
            .batchSize(batchSizes[i]),
            .slowDownInput(bufSlowDown[i]),
            .read(bufReads[i]),
            .botOut(bufBots[i]),
            .validBotPermutesOut(bufMasks[i])
        );
    end

    // Idle buffers drive zeros, so OR gives the one being read
    always_comb begin
        mergedBot = '0;
        mergedMask = '0;
        for (int i = 0; i < `NUM_SOURCES; i++) begin
            mergedBot = mergedBot | bufBots[i];
            mergedMask = mergedMask | bufMasks[i];
        end
    end

    // Full batch queue holds back every source
    assign slowDownInputs = batchQueueNearlyFull ? '1 : bufSlowDown;

    batchDispatcher dispatcher (
        .clk(clk),
        .rst(rst),
        .batchesDone(batchesDone),
        .batchSizes(batchSizes),
        .batchQueueNearlyFull(batchQueueNearlyFull),
        .reads(bufReads),
        .permuterSlowDown(stageSlowDown),
        .itemWrite(itemWrite),
        .batchEnd(batchEnd)
    );

    botPermuterWithFifo permuterStage (
        .clk(clk),
        .rst(rst),
        .bot(mergedBot),
        .writeData(itemWrite || batchEnd),
        .validBotPermutes(mergedMask),
        .batchDone(batchEnd),
        .slowDownInput(stageSlowDown),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

endmodule

// File: logic/batchDispatcher.sv
`timescale 1ns/100ps

`include "permuter_cfg.svh"

module batchDispatcher (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`NUM_SOURCES-1:0]   batchesDone,
    input  permuterPkg::batchSizeT    batchSizes [`NUM_SOURCES],
    output logic                      batchQueueNearlyFull,
    output logic [`NUM_SOURCES-1:0]   reads,
    input  logic                      permuterSlowDown,
    output logic                      itemWrite,
    output logic                      batchEnd
);

    import permuterPkg::*;

    localparam int entryWidth = $bits(batchSizeT) + `NUM_SOURCES;
    localparam int readLatency = `BUFFER_READ_LATENCY;

    batchSizeT closeSize;
    logic [`BATCH_FIFO_DEPTH_LOG2:0] queueUsedw;
    logic queueEmpty;
    logic [entryWidth-1:0] queueHead;
    batchSizeT headSize;
    logic [`NUM_SOURCES-1:0] headSource;
    batchSizeT remaining;
    logic [`NUM_SOURCES-1:0] activeSource;
    logic batchIdle;
    logic loadBatch;
    logic issueRead;
    logic wasActive;
    logic endPulse;
    logic [readLatency-1:0] readPipe;
    logic [readLatency-1:0] endPipe;

    // Size of whichever source closes this cycle
    always_comb begin
        closeSize = '0;
        for (int i = 0; i < `NUM_SOURCES; i++) begin
            if (batchesDone[i]) begin
                closeSize = batchSizes[i];
            end
        end
    end

    syncFifo #(
        .WIDTH(entryWidth),
        .DEPTH_LOG2(`BATCH_FIFO_DEPTH_LOG2)
    ) batchSizeFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(|batchesDone),
        .dataIn({closeSize, batchesDone}),
        .readEnable(loadBatch),
        .dataOut(queueHead),
        .empty(queueEmpty),
        .full(),
        .usedw(queueUsedw)
    );

    assign {headSize, headSource} = queueHead;

    assign batchIdle = (remaining == '0);
    assign loadBatch = batchIdle && !queueEmpty && !permuterSlowDown;
    assign issueRead = !batchIdle && !permuterSlowDown;
    assign reads = issueRead ? activeSource : '0;

    // Count just ran out, or an empty batch was loaded last cycle
    assign endPulse = wasActive && batchIdle;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            wasActive <= 1'b0;
            readPipe <= '0;
            endPipe <= '0;
            batchQueueNearlyFull <= 1'b0;
        end else begin
            if (loadBatch) begin
                remaining <= headSize;
            end else if (issueRead) begin
                remaining <= remaining - 1'b1;
            end
            wasActive <= !batchIdle || loadBatch;
            readPipe <= readLatency'({readPipe, issueRead});
            endPipe <= readLatency'({endPipe, endPulse});
            batchQueueNearlyFull <= (queueUsedw >= `BATCH_SLOWDOWN_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        if (loadBatch) begin
            activeSource <= headSource;
        end
    end

    // Strobes line up with the buffer data on the merged bus
    assign itemWrite = readPipe[readLatency-1];
    assign batchEnd = endPipe[readLatency-1];

    // Sources must not close batches in the same cycle
    singleBatchClose: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(batchesDone)
    );

endmodule

// File: logic/batchBotBuffer.sv
`timescale 1ns/100ps

`include "permuter_cfg.svh"

module batchBotBuffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   write,
    input  permuterPkg::botT       botIn,
    input  permuterPkg::permMaskT  validBotPermutesIn,
    input  logic                   endBatch,
    output permuterPkg::batchSizeT batchSize,
    output logic                   slowDownInput,
    input  logic                   read,
    output permuterPkg::botT       botOut,
    output permuterPkg::permMaskT  validBotPermutesOut
);

    import permuterPkg::*;

    localparam int depth = 2 ** `BUFFER_DEPTH_LOG2;

    logic [$bits(botT)+$bits(permMaskT)-1:0] mem [depth];
    logic [`BUFFER_DEPTH_LOG2-1:0] writePtr;
    logic [`BUFFER_DEPTH_LOG2-1:0] readPtr;
    logic [`BUFFER_DEPTH_LOG2:0] usedCount;
    batchSizeT openCount;
    logic storeItem;

    // Items without any permutation are not worth storing
    assign storeItem = write && (validBotPermutesIn != '0);

    // Count includes a write landing in this cycle
    assign batchSize = openCount + batchSizeT'(storeItem);

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            usedCount <= '0;
            openCount <= '0;
            slowDownInput <= 1'b0;
        end else begin
            writePtr <= writePtr + `BUFFER_DEPTH_LOG2'(storeItem);
            readPtr <= readPtr + `BUFFER_DEPTH_LOG2'(read);
            usedCount <= usedCount + (`BUFFER_DEPTH_LOG2 + 1)'(storeItem)
                                   - (`BUFFER_DEPTH_LOG2 + 1)'(read);
            openCount <= endBatch ? '0 : batchSize;
            slowDownInput <= (usedCount >= `BUFFER_SLOWDOWN_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        if (storeItem) begin
            mem[writePtr] <= {botIn, validBotPermutesIn};
        end
    end

    // Zero when idle so the top can OR all buffers together
    always_ff @(posedge clk) begin
        if (read) begin
            {botOut, validBotPermutesOut} <= mem[readPtr];
        end else begin
            {botOut, validBotPermutesOut} <= '0;
        end
    end

    // Dispatcher only reads items of batches that were closed here
    noReadWhenEmpty: assert property (
        @(posedge clk) disable iff (rst)
        read |-> (usedCount != '0)
    );

endmodule

// File: logic/botPermuterWithFifo.sv
`timescale 1ns/100ps

`include "permuter_cfg.svh"

module botPermuterWithFifo (
    input  logic                   clk,
    input  logic                   rst,
    input  permuterPkg::botT       bot,
    input  logic                   writeData,
    input  permuterPkg::permMaskT  validBotPermutes,
    input  logic                   batchDone,
    output logic                   slowDownInput,
    output permuterPkg::botT       permutedBot,
    output logic                   permutedBotValid,
    output logic                   batchFinished,
    input  logic                   requestSlowDown
);

    import permuterPkg::*;

    localparam int fifoWidth = $bits(botT) + $bits(permMaskT) + 1;
    localparam int permLatency = `PERMUTER_LATENCY;

    logic [`INPUT_FIFO_DEPTH_LOG2:0] fifoUsedw;
    logic fifoEmpty;
    logic [fifoWidth-1:0] fifoHead;
    botT queuedBot;
    permMaskT queuedMask;
    logic queuedBatchDone;
    logic permuterDone;
    logic popEntry;
    logic [permLatency-1:0] finishPipe;

    assign {queuedBot, queuedMask, queuedBatchDone} = fifoHead;

    // A started burst always runs out, slow-down only holds the next pop
    assign popEntry = permuterDone && !fifoEmpty && !requestSlowDown;

    syncFifo #(
        .WIDTH(fifoWidth),
        .DEPTH_LOG2(`INPUT_FIFO_DEPTH_LOG2)
    ) inputFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeData),
        .dataIn({bot, validBotPermutes, batchDone}),
        .readEnable(popEntry),
        .dataOut(fifoHead),
        .empty(fifoEmpty),
        .full(),
        .usedw(fifoUsedw)
    );

    botPermuter permuter (
        .clk(clk),
        .rst(rst),
        .startNewBurst(popEntry),
        .botIn(queuedBot),
        .validBotPermutesIn(queuedMask),
        .done(permuterDone),
        .permutedBotValid(permutedBotValid),
        .permutedBot(permutedBot)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            slowDownInput <= 1'b0;
            finishPipe <= '0;
        end else begin
            slowDownInput <= (fifoUsedw > `INPUT_SLOWDOWN_LEVEL);
            // Match the permuter latency so the pulse trails the last bot
            finishPipe <= permLatency'({finishPipe, popEntry && queuedBatchDone});
        end
    end

    assign batchFinished = finishPipe[permLatency-1];

    // End of batch never shares a cycle with a permuted bot
    finishAfterLastBot: assert property (
        @(posedge clk) disable iff (rst)
        batchFinished |-> !permutedBotValid
    );

endmodule

// File: logic/botPermuter.sv
`timescale 1ns/100ps

module botPermuter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   startNewBurst,
    input  permuterPkg::botT       botIn,
    input  permuterPkg::permMaskT  validBotPermutesIn,
    output logic                   done,
    output logic                   permutedBotValid,
    output permuterPkg::botT       permutedBot
);

    import permuterPkg::*;

    permStateE state;
    botT heldBot;
    permMaskT remMask;
    permSelE sel;
    permMaskT selBit;
    logic lastEmission;

    // Output bit j takes input bit k, k's top bits are j's A, B, C reordered
    function automatic botT permuteBot(input botT src, input permSelE how);
        botT res;
        logic [6:0] k;
        logic a;
        logic b;
        logic c;
        for (int j = 0; j < 128; j++) begin
            a = j[6];
            b = j[5];
            c = j[4];
            case (how)
                PERM_ACB: k[6:4] = {a, c, b};
                PERM_BAC: k[6:4] = {b, a, c};
                PERM_BCA: k[6:4] = {b, c, a};
                PERM_CAB: k[6:4] = {c, a, b};
                PERM_CBA: k[6:4] = {c, b, a};
                default:  k[6:4] = {a, b, c};
            endcase
            k[3:0] = j[3:0];
            res[j] = src[k];
        end
        return res;
    endfunction

    // Highest remaining mask bit goes first
    always_comb begin
        sel = PERM_CBA;
        for (int i = 0; i < 6; i++) begin
            if (remMask[i]) begin
                sel = permSelE'(3'(i));
            end
        end
    end

    assign selBit = permMaskT'(1) << sel;
    assign lastEmission = ((remMask & ~selBit) == '0);

    // Also ready in the last emission so bursts chain without a gap
    assign done = (state == IDLE) || lastEmission;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            remMask <= '0;
            permutedBotValid <= 1'b0;
        end else begin
            permutedBotValid <= (state == EMIT);
            if (startNewBurst && (validBotPermutesIn != '0)) begin
                state <= EMIT;
                remMask <= validBotPermutesIn;
            end else if (state == EMIT) begin
                remMask <= remMask & ~selBit;
                if (lastEmission) begin
                    state <= IDLE;
                end
            end
        end
    end

    // Stage one holds the bot, stage two the permuted result
    always_ff @(posedge clk) begin
        if (startNewBurst && (validBotPermutesIn != '0)) begin
            heldBot <= botIn;
        end
        permutedBot <= permuteBot(heldBot, sel);
    end

endmodule

// File: logic/syncFifo.sv
`timescale 1ns/100ps

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic                  readEnable,
    output logic [WIDTH-1:0]      dataOut,
    output logic                  empty,
    output logic                  full,
    output logic [DEPTH_LOG2:0]   usedw
);

    localparam int depth = 2 ** DEPTH_LOG2;

    logic [WIDTH-1:0] mem [depth];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;

    // Head word is visible before the read strobe
    assign dataOut = mem[readPtr];
    assign empty = (usedw == '0);
    assign full = (usedw == (DEPTH_LOG2 + 1)'(depth));

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
        end else begin
            writePtr <= writePtr + DEPTH_LOG2'(writeEnable);
            readPtr <= readPtr + DEPTH_LOG2'(readEnable);
            usedw <= usedw + (DEPTH_LOG2 + 1)'(writeEnable)
                           - (DEPTH_LOG2 + 1)'(readEnable);
        end
    end

    // Callers must respect the slow-down levels upstream
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        !(writeEnable && full)
    );

    // Pop only what has been queued
    noReadWhenEmpty: assert property (
        @(posedge clk) disable iff (rst)
        !(readEnable && empty)
    );

endmodule

// File: logic/permuterPkg.sv
package permuterPkg;

    // Truth table of a 7-input function, index bits 6..4 are A, B, C
    typedef logic [127:0] botT;

    // One bit per permutation of A, B and C, bit 5 is identity
    typedef logic [5:0] permMaskT;

    // Item count of one batch
    typedef logic [5:0] batchSizeT;

    // Encoding equals the mask bit position of each permutation
    typedef enum logic [2:0] {
        PERM_CBA = 3'd0,
        PERM_CAB = 3'd1,
        PERM_BCA = 3'd2,
        PERM_BAC = 3'd3,
        PERM_ACB = 3'd4,
        PERM_ABC = 3'd5
    } permSelE;

    typedef enum logic {
        IDLE = 1'b0,
        EMIT = 1'b1
    } permStateE;

endpackage

// File: logic/permuter_cfg.svh
`ifndef PERMUTER_CFG_SVH
`define PERMUTER_CFG_SVH

// Producing sources feeding the batch buffers
`define NUM_SOURCES 4

// Per-source batch buffer, 64 items
`define BUFFER_DEPTH_LOG2 6
`define BUFFER_SLOWDOWN_LEVEL 48

// Queue in front of the permutation generator
`define INPUT_FIFO_DEPTH_LOG2 5
`define INPUT_SLOWDOWN_LEVEL 16

// Queue of closed batches (size plus one-hot source)
`define BATCH_FIFO_DEPTH_LOG2 4
`define BATCH_SLOWDOWN_LEVEL 12

// Cycles from read strobe to data on the merged bus
`define BUFFER_READ_LATENCY 1
// Cycles from pop to first permuted bot
`define PERMUTER_LATENCY 2

`endif
